/* dual_issue.f */
+incdir+include
design/issue_pkg.sv
design/inst_classify.sv
design/pair_hazard.sv
design/issue_csr.sv
design/dual_issue_stage.sv
testbench/tb_dual_issue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dual issue testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f dual_issue.f --top-module tb_dual_issue -Mdir obj_dir

./obj_dir/Vtb_dual_issue 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

/* include/tb_issue_model.svh */
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

typedef struct packed {
  issue_pkg::pair_t replay;
  issue_pkg::pair_t issue;
  logic             load_stall;
  logic             split;
  logic             lane_conflict;
  logic [1:0]       issued;
} model_step_t;

function automatic issue_pkg::lane_t lane_class(input logic [31:0] inst);
  logic [5:0] op;
  op = inst[31:26];
  if (op[5:4] == 2'b10) return issue_pkg::lane_memory;
  if (op[5:4] == 2'b11 || op == `ISSUE_OP_CMP || op == `ISSUE_OP_TEST ||
      op == `ISSUE_OP_CMPI || op == `ISSUE_OP_TESTI)
    return issue_pkg::lane_branch;
  return issue_pkg::lane_any;
endfunction

function automatic logic reads_reg(input logic [31:0] inst, input logic [4:0] r);
  logic [5:0] op;
  logic       use_rs;
  logic       use_rt;
  op = inst[31:26];
  case (op[5:4])
    2'b00: begin
      use_rs = op != `ISSUE_OP_NOP;
      use_rt = op != `ISSUE_OP_NOP;
    end
    2'b01: begin
      use_rs = 1'b1;
      use_rt = 1'b0;
    end
    2'b10: begin
      use_rs = op == `ISSUE_OP_LW || op == `ISSUE_OP_SW;
      use_rt = op == `ISSUE_OP_SW || op == `ISSUE_OP_SA;
    end
    default: begin
      use_rs = op == `ISSUE_OP_JR;
      use_rt = 1'b0;
    end
  endcase
  return (use_rs && inst[25:21] == r) || (use_rt && inst[20:16] == r);
endfunction

function automatic logic dest_reg(input logic [31:0] inst, output logic [4:0] r);
  logic [5:0] op;
  op = inst[31:26];
  r  = inst[20:16];
  if (op[5:4] == 2'b00) begin
    r = inst[15:11];  // register alu writes rd.
    return op != `ISSUE_OP_NOP;
  end
  if (op[5:4] == 2'b01) return 1'b1;
  return op == `ISSUE_OP_LW || op == `ISSUE_OP_LA;
endfunction

// one cycle of the issue stage.
function automatic model_step_t issue_step(input issue_pkg::pair_t replay,
                                           input issue_pkg::pair_t fetch,
                                           input logic [31:0] mi,
                                           input issue_pkg::mem_op_t mo,
                                           input logic si,
                                           input logic fl);
  model_step_t      s;
  issue_pkg::pair_t w;
  issue_pkg::pair_t head;
  logic [4:0]       d0;
  logic             wr0;
  logic             both;
  logic             hit;
  logic             split;
  logic             conflict;
  s = '0;
  if (fl) return s;
  w    = (replay.slot0.inst != '0 || replay.slot1.inst != '0) ? replay : fetch;
  both = w.slot0.inst != '0 && w.slot1.inst != '0;
  hit  = mo == issue_pkg::mem_read &&
         (reads_reg(w.slot0.inst, mi[20:16]) || reads_reg(w.slot1.inst, mi[20:16]));
  wr0      = dest_reg(w.slot0.inst, d0);
  split    = both && (si || (wr0 && reads_reg(w.slot1.inst, d0)));
  conflict = both && lane_class(w.slot0.inst) == lane_class(w.slot1.inst) &&
             lane_class(w.slot0.inst) != issue_pkg::lane_any;
  head = w;
  if (hit) begin
    s.replay     = w;
    head         = '0;
    s.load_stall = 1'b1;
  end else if (split || conflict) begin
    s.replay.slot1  = w.slot1;
    head.slot1      = '0;
    s.split         = split;
    s.lane_conflict = !split;
  end
  s.issued = 2'(head.slot0.inst != '0) + 2'(head.slot1.inst != '0);
  if (lane_class(head.slot0.inst) == issue_pkg::lane_memory ||
      lane_class(head.slot1.inst) == issue_pkg::lane_branch)
    s.issue = {head.slot1, head.slot0};  // branch left, memory right.
  else
    s.issue = head;
  return s;
endfunction

`endif

/* testbench/tb_dual_issue.sv */
`include "issue_params.svh"

module tb_dual_issue;

  localparam int          num_pairs = 64;  // upper bound on presented pairs.
  localparam logic [5:0]  op_add    = 6'b000010;
  localparam logic [5:0]  op_addi   = 6'b010000;
  localparam logic [5:0]  op_beq    = 6'b110000;

  logic                       clk;
  logic                       reset;
  logic                       flush;
  issue_pkg::pair_t           fetch_pair;
  logic                       stall;
  logic [`ISSUE_INST_W-1:0]   mem_inst;
  issue_pkg::mem_op_t         mem_op;
  issue_pkg::pair_t           issue_pair;
  logic [`ISSUE_CSR_AW-1:0]   awaddr, araddr;
  logic                       awvalid, awready, wvalid, wready, bvalid, bready;
  logic                       arvalid, arready, rvalid, rready;
  logic [`ISSUE_CSR_DW-1:0]   wdata, rdata;
  logic [`ISSUE_CSR_DW/8-1:0] wstrb;
  logic [1:0]                 bresp, rresp;

  integer           seed;
  logic [7:0]       next_id;
  logic             single_issue_exp;
  issue_pkg::pair_t model_replay;
  issue_pkg::pair_t exp_issue;
  logic [31:0]      cnt_load, cnt_split, cnt_conflict, cnt_issued;

  `include "tb_issue_model.svh"

  dual_issue_stage dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (20 * num_pairs + 200) @(posedge clk);
    $display("timeout: the tests did not finish in time");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input logic [143:0] got, input logic [143:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "check failed");
    end
  endtask

  //////////////////////////////
  // compare against the model

  always @(negedge clk) begin
    model_step_t st;
    logic        exp_stall;
    if (reset) begin
      model_replay = '0;
      exp_issue    = '0;
    end else begin
      exp_stall = model_replay.slot0.inst != '0 || model_replay.slot1.inst != '0;
      check_value(issue_pair, exp_issue, "issue_pair");
      check_value(stall, exp_stall, "stall");
      st = issue_step(model_replay, fetch_pair, mem_inst, mem_op, single_issue_exp, flush);
      model_replay = st.replay;
      exp_issue    = st.issue;
      cnt_load     = cnt_load + 32'(st.load_stall);
      cnt_split    = cnt_split + 32'(st.split);
      cnt_conflict = cnt_conflict + 32'(st.lane_conflict);
      cnt_issued   = cnt_issued + 32'(st.issued);
    end
  end

  function automatic logic [31:0] encode_inst(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd);
    return {op, rs, rt, rd, 11'h0};
  endfunction

  function automatic logic [31:0] random_inst();
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    case ($unsigned($random(seed)) % 12)
      0: op = op_add;
      1: op = op_addi;
      2: op = op_beq;
      3: op = `ISSUE_OP_CMP;
      4: op = `ISSUE_OP_TEST;
      5: op = `ISSUE_OP_CMPI;
      6: op = `ISSUE_OP_TESTI;
      7: op = `ISSUE_OP_LW;
      8: op = `ISSUE_OP_SW;
      9: op = `ISSUE_OP_LA;
      10: op = `ISSUE_OP_SA;
      default: op = `ISSUE_OP_JR;
    endcase
    rs = 5'($unsigned($random(seed)) % 8);  // few registers, more hazards.
    rt = 5'($unsigned($random(seed)) % 8);
    rd = 5'($unsigned($random(seed)) % 8);
    return encode_inst(op, rs, rt, rd);
  endfunction

  // holds the pair until an edge with stall low takes it.
  task automatic present(input logic [31:0] i0, input logic [31:0] i1,
                         input logic [31:0] mi = '0,
                         input issue_pkg::mem_op_t mo = issue_pkg::mem_none);
    logic taken;
    fetch_pair.slot0.inst = i0;
    fetch_pair.slot0.pc   = {24'h0, next_id} << 2;
    fetch_pair.slot0.id   = next_id;
    fetch_pair.slot1.inst = i1;
    fetch_pair.slot1.pc   = {24'h0, next_id + 8'd1} << 2;
    fetch_pair.slot1.id   = next_id + 8'd1;
    next_id  = next_id + 8'd2;
    mem_inst = mi;
    mem_op   = mo;
    taken    = 1'b0;
    while (!taken) begin
      taken = !stall;
      @(posedge clk);
      #1;
      mem_op = issue_pkg::mem_none;  // memory stage moves on.
    end
    fetch_pair = '0;
  endtask

  task automatic drain();
    while (stall) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  //////////////////////////////
  // axi4-lite master

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (awvalid || wvalid) begin
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(posedge clk);
      #1;
      if (aw_hs) awvalid = 1'b0;
      if (w_hs) wvalid = 1'b0;
    end
    bready = 1'b1;
    b_hs   = 1'b0;
    while (!b_hs) begin
      b_hs = bvalid;
      @(posedge clk);
      #1;
    end
    bready = 1'b0;
    check_value(bresp, 2'b00, "bresp");
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    logic ar_hs;
    logic r_hs;
    araddr  = addr;
    arvalid = 1'b1;
    ar_hs   = 1'b0;
    while (!ar_hs) begin
      ar_hs = arready;
      @(posedge clk);
      #1;
    end
    arvalid = 1'b0;
    rready  = 1'b1;
    r_hs    = 1'b0;
    while (!r_hs) begin
      r_hs = rvalid;
      if (rvalid) data = rdata;
      @(posedge clk);
      #1;
    end
    rready = 1'b0;
    check_value(rresp, 2'b00, "rresp");
  endtask

  task automatic write_ctrl(input logic [31:0] data);
    logic [31:0] v;
    axi_write(8'h00, data);
    single_issue_exp = data[0];
    if (data[1]) begin
      cnt_load     = '0;
      cnt_split    = '0;
      cnt_conflict = '0;
      cnt_issued   = '0;
    end
    axi_read(8'h00, v);
    check_value(v, {31'h0, data[0]}, "control register");
  endtask

  task automatic check_counters();
    logic [31:0] v;
    axi_read(8'h04, v);
    check_value(v, cnt_load, "load stall count");
    axi_read(8'h08, v);
    check_value(v, cnt_split, "split count");
    axi_read(8'h0c, v);
    check_value(v, cnt_conflict, "lane conflict count");
    axi_read(8'h10, v);
    check_value(v, cnt_issued, "issued count");
  endtask

  initial begin
    logic [4:0] load_rt;
    seed             = 32'he1b4;
    reset            = 1'b1;
    flush            = 1'b0;
    fetch_pair       = '0;
    mem_inst         = '0;
    mem_op           = issue_pkg::mem_none;
    awaddr           = '0;
    awvalid          = 1'b0;
    wdata            = '0;
    wstrb            = '0;
    wvalid           = 1'b0;
    bready           = 1'b0;
    araddr           = '0;
    arvalid          = 1'b0;
    rready           = 1'b0;
    next_id          = 8'd1;
    single_issue_exp = 1'b0;
    cnt_load         = '0;
    cnt_split        = '0;
    cnt_conflict     = '0;
    cnt_issued       = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    present(encode_inst(op_add, 1, 2, 3), encode_inst(op_add, 4, 5, 6));
    present(encode_inst(op_addi, 7, 8, 0), encode_inst(op_add, 9, 10, 11));
    drain();
    // load-use in slot0, then a store in slot1.
    present(encode_inst(op_add, 5, 6, 8), encode_inst(op_add, 1, 2, 9),
            encode_inst(`ISSUE_OP_LW, 1, 5, 0), issue_pkg::mem_read);
    drain();
    present(encode_inst(op_add, 1, 2, 3), encode_inst(`ISSUE_OP_SW, 4, 12, 0),
            encode_inst(`ISSUE_OP_LW, 2, 12, 0), issue_pkg::mem_read);
    drain();
    present(encode_inst(op_add, 1, 2, 7), encode_inst(op_add, 7, 3, 4));
    present(encode_inst(`ISSUE_OP_LW, 2, 13, 0), encode_inst(op_add, 13, 1, 5));
    drain();
    check_counters();
    write_ctrl(32'h1);
    present(encode_inst(op_add, 1, 2, 3), encode_inst(op_add, 4, 5, 6));
    present(encode_inst(`ISSUE_OP_LW, 1, 2, 0), encode_inst(`ISSUE_OP_CMP, 3, 4, 5));
    drain();
    write_ctrl(32'h0);

    // lane steering and conflicts.
    present(encode_inst(`ISSUE_OP_LW, 1, 2, 0), encode_inst(`ISSUE_OP_CMP, 3, 4, 5));
    present(encode_inst(op_add, 1, 2, 3), encode_inst(`ISSUE_OP_JR, 6, 0, 0));
    present(encode_inst(`ISSUE_OP_SA, 0, 4, 0), encode_inst(op_add, 1, 2, 3));
    present(encode_inst(`ISSUE_OP_JR, 1, 0, 0), encode_inst(op_beq, 0, 0, 0));
    present(encode_inst(`ISSUE_OP_SW, 1, 2, 0), encode_inst(`ISSUE_OP_LA, 0, 3, 0));
    drain();

    present(encode_inst(op_add, 1, 2, 7), encode_inst(op_add, 7, 7, 8));
    flush = 1'b1;  // slot1 is waiting in replay.
    @(posedge clk);
    #1;
    flush = 1'b0;
    drain();

    for (int n = 0; n < 40; n++) begin
      load_rt = 5'($unsigned($random(seed)) % 8);
      if ($unsigned($random(seed)) % 4 == 0)
        present(random_inst(), random_inst(),
                encode_inst(`ISSUE_OP_LW, 0, load_rt, 0), issue_pkg::mem_read);
      else
        present(random_inst(), random_inst());
    end
    drain();
    check_counters();
    write_ctrl(32'h2);  // counter clear.
    check_counters();

    $display("Regression passed");
    $finish;
  end

endmodule

/* design/dual_issue_stage.sv */
`include "issue_params.svh"

module dual_issue_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        flush,
  input  issue_pkg::pair_t            fetch_pair,
  output logic                        stall,
  input  logic [`ISSUE_INST_W-1:0]    mem_inst,
  input  issue_pkg::mem_op_t          mem_op,
  output issue_pkg::pair_t            issue_pair,
  input  logic [`ISSUE_CSR_AW-1:0]    awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`ISSUE_CSR_DW-1:0]    wdata,
  input  logic [`ISSUE_CSR_DW/8-1:0]  wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`ISSUE_CSR_AW-1:0]    araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`ISSUE_CSR_DW-1:0]    rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready
);

  issue_pkg::hazard_events_t events;
  logic                      single_issue;

  pair_hazard hazard0 (
    .clk, .reset, .flush, .fetch_pair, .mem_inst, .mem_op,
    .single_issue, .stall, .issue_pair, .events
  );

  issue_csr csr0 (
    .clk, .reset, .events, .single_issue,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

endmodule

/* design/issue_csr.sv */
`include "issue_params.svh"

module issue_csr (
  input  logic                        clk,
  input  logic                        reset,
  input  issue_pkg::hazard_events_t   events,
  output logic                        single_issue,
  input  logic [`ISSUE_CSR_AW-1:0]    awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`ISSUE_CSR_DW-1:0]    wdata,
  input  logic [`ISSUE_CSR_DW/8-1:0]  wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`ISSUE_CSR_AW-1:0]    araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`ISSUE_CSR_DW-1:0]    rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready
);

  localparam logic [`ISSUE_CSR_AW-1:0] ctrl_addr     = 'h00;
  localparam logic [`ISSUE_CSR_AW-1:0] load_addr     = 'h04;
  localparam logic [`ISSUE_CSR_AW-1:0] split_addr    = 'h08;
  localparam logic [`ISSUE_CSR_AW-1:0] conflict_addr = 'h0c;
  localparam logic [`ISSUE_CSR_AW-1:0] issued_addr   = 'h10;

  logic                       aw_full, w_full, aw_acc, w_acc, do_write, clear_cnt;
  logic [`ISSUE_CSR_AW-1:0]   aw_q, wr_addr;
  logic [`ISSUE_CSR_DW-1:0]   w_q, wr_data, rd_mux;
  logic [`ISSUE_CSR_DW/8-1:0] strb_q, wr_strb;
  issue_pkg::counter_t        load_cnt, split_cnt, conflict_cnt, issued_cnt;

  function automatic issue_pkg::counter_t sat_add(issue_pkg::counter_t value,
                                                  logic [1:0] inc);
    logic [`ISSUE_CSR_DW:0] sum;
    sum = {1'b0, value} + inc;
    return sum[`ISSUE_CSR_DW] ? '1 : sum[`ISSUE_CSR_DW-1:0];
  endfunction

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  //////////////////////////////
  // write channel

  assign aw_acc    = awvalid && awready;
  assign w_acc     = wvalid && wready;
  assign do_write  = (aw_full || aw_acc) && (w_full || w_acc);
  assign wr_addr   = aw_full ? aw_q : awaddr;
  assign wr_data   = w_full ? w_q : wdata;
  assign wr_strb   = w_full ? strb_q : wstrb;
  assign clear_cnt = do_write && wr_addr == ctrl_addr && wr_strb[0] && wr_data[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      awready      <= 1'b0;
      wready       <= 1'b0;
      aw_full      <= 1'b0;
      w_full       <= 1'b0;
      bvalid       <= 1'b0;
      single_issue <= 1'b0;
    end else begin
      awready <= awvalid && !awready && !aw_full && !bvalid;  // one-cycle pulse.
      wready  <= wvalid && !wready && !w_full && !bvalid;
      if (aw_acc) aw_full <= 1'b1;
      if (w_acc) w_full <= 1'b1;
      if (do_write) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
        bvalid  <= 1'b1;
        if (wr_addr == ctrl_addr && wr_strb[0]) single_issue <= wr_data[0];
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_acc) aw_q <= awaddr;
    if (w_acc) begin
      w_q    <= wdata;
      strb_q <= wstrb;
    end
  end

  //////////////////////////////
  // read channel

  always_comb begin
    case (araddr)
      ctrl_addr:     rd_mux = {{(`ISSUE_CSR_DW-1){1'b0}}, single_issue};
      load_addr:     rd_mux = load_cnt;
      split_addr:    rd_mux = split_cnt;
      conflict_addr: rd_mux = conflict_cnt;
      issued_addr:   rd_mux = issued_cnt;
      default:       rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (arvalid && arready) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) rdata <= rd_mux;
  end

  // clear wins over a same-cycle event.
  always_ff @(posedge clk) begin
    if (reset || clear_cnt) begin
      load_cnt     <= '0;
      split_cnt    <= '0;
      conflict_cnt <= '0;
      issued_cnt   <= '0;
    end else begin
      load_cnt     <= sat_add(load_cnt, {1'b0, events.load_stall});
      split_cnt    <= sat_add(split_cnt, {1'b0, events.split});
      conflict_cnt <= sat_add(conflict_cnt, {1'b0, events.lane_conflict});
      issued_cnt   <= sat_add(issued_cnt, events.issued);
    end
  end

  // no new write is taken while a response waits.
  a_write_gap: assert property (@(posedge clk) disable iff (reset)
    bvalid |-> !awready && !wready)
    else $error("write accepted while a response is pending");

endmodule

/* design/pair_hazard.sv */
`include "issue_params.svh"

module pair_hazard (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  issue_pkg::pair_t          fetch_pair,
  input  logic [`ISSUE_INST_W-1:0]  mem_inst,
  input  issue_pkg::mem_op_t        mem_op,
  input  logic                      single_issue,
  output logic                      stall,
  output issue_pkg::pair_t          issue_pair,
  output issue_pkg::hazard_events_t events
);

  issue_pkg::pair_t     replay_q;
  issue_pkg::pair_t     replay_d;
  issue_pkg::pair_t     work;
  issue_pkg::pair_t     head;
  issue_pkg::pair_t     issue_d;
  issue_pkg::reg_mask_t src0, dst0, src1;
  issue_pkg::reg_idx_t  rs0, rt0, rd0, rs1, rt1;
  issue_pkg::reg_idx_t  load_rt, dst_reg0;
  issue_pkg::lane_t     lane0, lane1;
  logic                 full0, full1;
  logic                 load_hit, dep, split, conflict, defer1, swap;
  logic                 mem_in_lane0, br_in_lane1;
  logic [`ISSUE_OPC_MSB-`ISSUE_OPC_LSB:0] out_opc1;

  assign stall = (replay_q.slot0.inst != '0) || (replay_q.slot1.inst != '0);
  assign work  = stall ? replay_q : fetch_pair;
  assign full0 = work.slot0.inst != '0;
  assign full1 = work.slot1.inst != '0;

  inst_classify cls0 (
    .inst(work.slot0.inst), .src_mask(src0), .dst_mask(dst0),
    .rs(rs0), .rt(rt0), .rd(rd0), .lane(lane0)
  );

  inst_classify cls1 (
    .inst(work.slot1.inst), .src_mask(src1), .dst_mask(),
    .rs(rs1), .rt(rt1), .rd(), .lane(lane1)
  );

  //////////////////////////////
  // hazard checks

  assign load_rt  = mem_inst[`ISSUE_RT_MSB:`ISSUE_RT_LSB];
  assign load_hit = (mem_op == issue_pkg::mem_read) &&
                    ((src0.rs && rs0 == load_rt) || (src0.rt && rt0 == load_rt) ||
                     (src1.rs && rs1 == load_rt) || (src1.rt && rt1 == load_rt));

  assign dst_reg0 = dst0.rd ? rd0 : rt0;
  assign dep      = (dst0.rd || dst0.rt) &&
                    ((src1.rs && rs1 == dst_reg0) || (src1.rt && rt1 == dst_reg0));
  assign split    = full0 && full1 && (dep || single_issue);
  assign conflict = full0 && full1 && (lane0 == lane1) && (lane0 != issue_pkg::lane_any);
  assign defer1   = split || conflict;

  //////////////////////////////
  // replay and steering

  always_comb begin
    head     = work;
    replay_d = '0;
    if (load_hit) begin
      head     = '0;  // nothing issues this cycle.
      replay_d = work;
    end else if (defer1) begin
      head.slot1     = '0;
      replay_d.slot1 = work.slot1;  // keeps its slot position.
    end
  end

  // branch to lane 0, memory op to lane 1.
  assign swap    = (lane0 == issue_pkg::lane_memory) ||
                   (lane1 == issue_pkg::lane_branch && !defer1);
  assign issue_d = swap ? {head.slot1, head.slot0} : head;

  always_comb begin
    events = '0;
    if (!flush) begin
      events.load_stall    = load_hit;
      events.split         = !load_hit && split;
      events.lane_conflict = !load_hit && !split && conflict;
      events.issued        = {1'b0, head.slot0.inst != '0} + {1'b0, head.slot1.inst != '0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      replay_q   <= '0;
      issue_pair <= '0;
    end else begin
      replay_q   <= replay_d;
      issue_pair <= issue_d;
    end
  end

  //////////////////////////////
  // checks

  assign out_opc1     = issue_pair.slot1.inst[`ISSUE_OPC_MSB:`ISSUE_OPC_LSB];
  assign mem_in_lane0 = issue_pair.slot0.inst[`ISSUE_GRP_MSB:`ISSUE_GRP_LSB] == `ISSUE_GRP_MEM;
  assign br_in_lane1  = issue_pair.slot1.inst[`ISSUE_GRP_MSB:`ISSUE_GRP_LSB] == `ISSUE_GRP_BR ||
                        out_opc1 == `ISSUE_OP_CMP || out_opc1 == `ISSUE_OP_TEST ||
                        out_opc1 == `ISSUE_OP_CMPI || out_opc1 == `ISSUE_OP_TESTI;

  // a load stall brings back the same pair.
  a_load_replay: assert property (@(posedge clk) disable iff (reset)
    load_hit && !flush |=> stall && work == $past(work))
    else $error("load stall did not replay the whole pair");

  a_lane_fit: assert property (@(posedge clk) disable iff (reset)
    !(mem_in_lane0 || br_in_lane1))
    else $error("issued pair violates lane classes");

endmodule

/* design/inst_classify.sv */
`include "issue_params.svh"

module inst_classify (
  input  logic [`ISSUE_INST_W-1:0] inst,
  output issue_pkg::reg_mask_t     src_mask,
  output issue_pkg::reg_mask_t     dst_mask,
  output issue_pkg::reg_idx_t      rs,
  output issue_pkg::reg_idx_t      rt,
  output issue_pkg::reg_idx_t      rd,
  output issue_pkg::lane_t         lane
);

  logic [`ISSUE_OPC_MSB-`ISSUE_OPC_LSB:0] opc;
  logic [1:0]                             grp;
  logic                                   is_cmp;

  assign opc = inst[`ISSUE_OPC_MSB:`ISSUE_OPC_LSB];
  assign grp = inst[`ISSUE_GRP_MSB:`ISSUE_GRP_LSB];
  assign rs  = inst[`ISSUE_RS_MSB:`ISSUE_RS_LSB];
  assign rt  = inst[`ISSUE_RT_MSB:`ISSUE_RT_LSB];
  assign rd  = inst[`ISSUE_RD_MSB:`ISSUE_RD_LSB];

  // compares feed the branch unit.
  assign is_cmp = (opc == `ISSUE_OP_CMP) || (opc == `ISSUE_OP_TEST) ||
                  (opc == `ISSUE_OP_CMPI) || (opc == `ISSUE_OP_TESTI);

  always_comb begin
    src_mask = '0;
    dst_mask = '0;
    lane     = is_cmp ? issue_pkg::lane_branch : issue_pkg::lane_any;
    case (grp)
      `ISSUE_GRP_ALU: begin
        if (opc != `ISSUE_OP_NOP) begin  // nop and empty slot use nothing.
          src_mask.rs = 1'b1;
          src_mask.rt = 1'b1;
          dst_mask.rd = 1'b1;
        end
      end
      `ISSUE_GRP_ALUI: begin
        src_mask.rs = 1'b1;
        dst_mask.rt = 1'b1;
      end
      `ISSUE_GRP_MEM: begin
        lane = issue_pkg::lane_memory;
        case (opc)
          `ISSUE_OP_LW: begin
            src_mask.rs = 1'b1;
            dst_mask.rt = 1'b1;
          end
          `ISSUE_OP_SW: begin
            src_mask.rs = 1'b1;
            src_mask.rt = 1'b1;
          end
          `ISSUE_OP_LA: dst_mask.rt = 1'b1;
          `ISSUE_OP_SA: src_mask.rt = 1'b1;
          default: ;
        endcase
      end
      default: begin
        lane        = issue_pkg::lane_branch;
        src_mask.rs = (opc == `ISSUE_OP_JR);  // other branches are immediate.
      end
    endcase
  end

endmodule

/* design/issue_pkg.sv */
`include "issue_params.svh"

package issue_pkg;

  //////////////////////////////
  // instruction path

  typedef logic [`ISSUE_REG_W-1:0] reg_idx_t;

  typedef struct packed {
    logic [`ISSUE_INST_W-1:0] inst;  // all zero means empty.
    logic [`ISSUE_ADDR_W-1:0] pc;
    logic [`ISSUE_ID_W-1:0]   id;
  } slot_t;

  typedef struct packed {
    slot_t slot0;
    slot_t slot1;
  } pair_t;

  typedef enum logic [1:0] {
    lane_any,
    lane_branch,
    lane_memory
  } lane_t;

  typedef struct packed {
    logic rs;
    logic rt;
    logic rd;
  } reg_mask_t;

  typedef enum logic [1:0] {
    mem_none,
    mem_read,
    mem_write
  } mem_op_t;

  //////////////////////////////
  // event reporting

  typedef struct packed {
    logic       load_stall;
    logic       split;
    logic       lane_conflict;
    logic [1:0] issued;  // slots sent this cycle.
  } hazard_events_t;

  typedef logic [`ISSUE_CSR_DW-1:0] counter_t;

endpackage

/* include/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// datapath widths
`define ISSUE_INST_W    32
`define ISSUE_ADDR_W    32
`define ISSUE_ID_W      8
`define ISSUE_NUM_REGS  32
`define ISSUE_REG_W     $clog2(`ISSUE_NUM_REGS)

// register port
`define ISSUE_CSR_AW    8
`define ISSUE_CSR_DW    32

// instruction fields
`define ISSUE_OPC_MSB   31
`define ISSUE_OPC_LSB   26
`define ISSUE_GRP_MSB   31
`define ISSUE_GRP_LSB   30
`define ISSUE_RS_MSB    25
`define ISSUE_RS_LSB    21
`define ISSUE_RT_MSB    20
`define ISSUE_RT_LSB    16
`define ISSUE_RD_MSB    15
`define ISSUE_RD_LSB    11

// opcode groups, top two opcode bits
`define ISSUE_GRP_ALU   2'b00
`define ISSUE_GRP_ALUI  2'b01
`define ISSUE_GRP_MEM   2'b10
`define ISSUE_GRP_BR    2'b11

`define ISSUE_OP_NOP    6'b000000
`define ISSUE_OP_CMP    6'b001000
`define ISSUE_OP_TEST   6'b001001
`define ISSUE_OP_CMPI   6'b011000
`define ISSUE_OP_TESTI  6'b011001
`define ISSUE_OP_LW     6'b100000
`define ISSUE_OP_SW     6'b100001
`define ISSUE_OP_LA     6'b100010
`define ISSUE_OP_SA     6'b100011
`define ISSUE_OP_JR     6'b111000

`endif
